//--- Makefile
# Verilator build and run of pcie_trans_tb

TOP = pcie_trans_tb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f list.f
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f list.f

clean:
	rm -rf obj_dir

//--- common/fifo_status_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// FIFO status flags, all registered inside the FIFO
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

interface fifo_status_if;

	logic empty;
	// count at or above the runtime threshold
	logic almost_full;
	logic full;
	// one cycle pulse, push dropped while full
	logic overflow;

	// the FIFO itself
	modport producer (output empty, output almost_full, output full, output overflow);

	// control, arbiter, top level pause
	modport observer (input empty, input almost_full, input full, input overflow);

endinterface

//--- common/trans_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// word layout and control constants; thresholds limit FIFO depth to 31
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package trans_pkg;

	// six bit transaction word
	localparam int WORD_W = 6;

	// bit positions inside the word
	localparam int VC_BIT = 5;
	localparam int DEST_BIT = 4;

	// one almost-full threshold, covers a count of 16
	localparam int THR_W = 5;

	// cfg word holds main, vc and dest thresholds
	localparam int CFG_W = 3 * THR_W;
	localparam int CFG_MAIN_LSB = 2 * THR_W;
	localparam int CFG_VC_LSB = THR_W;
	localparam int CFG_DEST_LSB = 0;

	// thresholds right after reset
	localparam logic [THR_W-1:0] DEF_THR_MAIN = 5'd3;
	localparam logic [THR_W-1:0] DEF_THR_VC = 5'd12;
	localparam logic [THR_W-1:0] DEF_THR_DEST = 5'd3;

	// control FSM states
	typedef enum logic [2:0] {
		RESET = 3'd0,
		INIT = 3'd1,
		IDLE = 3'd2,
		ACTIVE = 3'd3,
		// sticky, left only through reset
		ERROR = 3'd4
	} ctrl_state_t;

endpackage

//--- control/trans_ctrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cfg sampled only in INIT with init high; ERROR held until reset
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module trans_ctrl
	import trans_pkg::*;
(
	input  logic             clk,
	input  logic             reset_L,
	input  logic             init,
	input  logic [CFG_W-1:0] cfg,
	fifo_status_if.observer  main_stat,
	fifo_status_if.observer  vc0_stat,
	fifo_status_if.observer  vc1_stat,
	fifo_status_if.observer  d0_stat,
	fifo_status_if.observer  d1_stat,
	output logic [THR_W-1:0] thr_main,
	output logic [THR_W-1:0] thr_vc,
	output logic [THR_W-1:0] thr_dest,
	output logic             active,
	output logic             idle,
	output logic             error
);

	ctrl_state_t state;
	ctrl_state_t state_nxt;
	logic any_ovf;
	logic all_empty;

	// status reduction over the five FIFOs
	assign any_ovf = main_stat.overflow || vc0_stat.overflow || vc1_stat.overflow
		|| d0_stat.overflow || d1_stat.overflow;
	assign all_empty = main_stat.empty && vc0_stat.empty && vc1_stat.empty
		&& d0_stat.empty && d1_stat.empty;

	always_comb begin
		state_nxt = state;
		case (state)
			RESET: state_nxt = INIT;
			INIT: begin
				// overflow wins over init
				if (any_ovf)
					state_nxt = ERROR;
				else if (!init)
					state_nxt = IDLE;
			end
			IDLE, ACTIVE: begin
				if (any_ovf)
					state_nxt = ERROR;
				else if (init)
					state_nxt = INIT;
				else if (all_empty)
					state_nxt = IDLE;
				else
					state_nxt = ACTIVE;
			end
			ERROR: state_nxt = ERROR;
			default: state_nxt = RESET;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!reset_L)
			state <= RESET;
		else
			state <= state_nxt;
	end

	// thresholds, reloaded each cycle init is held
	always_ff @(posedge clk) begin
		if (!reset_L) begin
			thr_main <= DEF_THR_MAIN;
			thr_vc <= DEF_THR_VC;
			thr_dest <= DEF_THR_DEST;
		end else if (state == INIT && init) begin
			thr_main <= cfg[CFG_MAIN_LSB +: THR_W];
			thr_vc <= cfg[CFG_VC_LSB +: THR_W];
			thr_dest <= cfg[CFG_DEST_LSB +: THR_W];
		end
	end

	// one flag per state
	assign idle = (state == IDLE);
	assign active = (state == ACTIVE);
	assign error = (state == ERROR);

	// any FIFO overflow lands in ERROR on the next edge
	a_ovf_to_error: assert property (@(posedge clk) disable iff (!reset_L)
		any_ovf && state != RESET |=> state == ERROR);

endmodule

//--- hdl/pcie_trans.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// source must stop pushing while pause is high, or words are lost
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module pcie_trans
	import trans_pkg::*;
#(
	parameter int MAIN_DEPTH = 4,
	parameter int VC_DEPTH = 16,
	parameter int DEST_DEPTH = 4
) (
	input  logic              clk,
	input  logic              reset_L,
	input  logic              init,
	input  logic [CFG_W-1:0]  cfg,
	input  logic [WORD_W-1:0] in_data,
	input  logic              in_push,
	output logic              pause,
	output logic [WORD_W-1:0] out0_data,
	output logic              out0_valid,
	input  logic              out0_ready,
	output logic [WORD_W-1:0] out1_data,
	output logic              out1_valid,
	input  logic              out1_ready,
	output logic              active,
	output logic              idle,
	output logic              error
);

	fifo_status_if main_st ();
	fifo_status_if vc0_st ();
	fifo_status_if vc1_st ();
	fifo_status_if d0_st ();
	fifo_status_if d1_st ();

	logic [THR_W-1:0] thr_main;
	logic [THR_W-1:0] thr_vc;
	logic [THR_W-1:0] thr_dest;

	// main FIFO to vc split
	logic [WORD_W-1:0] m_data;
	logic m_valid, m_ready;
	// vc split to vc FIFOs
	logic [WORD_W-1:0] s1_0_data, s1_1_data;
	logic s1_0_valid, s1_0_ready, s1_1_valid, s1_1_ready;
	// vc FIFOs to arbiter
	logic [WORD_W-1:0] v0_data, v1_data;
	logic v0_valid, v0_ready, v1_valid, v1_ready;
	// arbiter to dest split
	logic [WORD_W-1:0] a_data;
	logic a_valid, a_ready;
	// dest split to dest FIFOs
	logic [WORD_W-1:0] s2_0_data, s2_1_data;
	logic s2_0_valid, s2_0_ready, s2_1_valid, s2_1_ready;

	assign pause = main_st.almost_full;

	// push-only FIFO inputs, ready while there is room
	assign s1_0_ready = !vc0_st.full;
	assign s1_1_ready = !vc1_st.full;
	assign s2_0_ready = !d0_st.full;
	assign s2_1_ready = !d1_st.full;

	trans_fifo #(.DEPTH(MAIN_DEPTH)) main_fifo (.clk, .reset_L, .in_data, .in_push,
		.out_data(m_data), .out_valid(m_valid), .out_ready(m_ready),
		.afull_thr(thr_main), .status(main_st));

	route_split #(.SEL_BIT(VC_BIT)) vc_split (.clk, .reset_L,
		.in_data(m_data), .in_valid(m_valid), .in_ready(m_ready),
		.out0_data(s1_0_data), .out0_valid(s1_0_valid), .out0_ready(s1_0_ready),
		.out1_data(s1_1_data), .out1_valid(s1_1_valid), .out1_ready(s1_1_ready));

	trans_fifo #(.DEPTH(VC_DEPTH)) vc0_fifo (.clk, .reset_L, .in_data(s1_0_data),
		.in_push(s1_0_valid && s1_0_ready), .out_data(v0_data), .out_valid(v0_valid),
		.out_ready(v0_ready), .afull_thr(thr_vc), .status(vc0_st));

	trans_fifo #(.DEPTH(VC_DEPTH)) vc1_fifo (.clk, .reset_L, .in_data(s1_1_data),
		.in_push(s1_1_valid && s1_1_ready), .out_data(v1_data), .out_valid(v1_valid),
		.out_ready(v1_ready), .afull_thr(thr_vc), .status(vc1_st));

	vc_arbiter arb (.clk, .reset_L,
		.vc0_data(v0_data), .vc0_valid(v0_valid), .vc0_ready(v0_ready),
		.vc1_data(v1_data), .vc1_valid(v1_valid), .vc1_ready(v1_ready),
		.d0_stat(d0_st), .d1_stat(d1_st),
		.out_data(a_data), .out_valid(a_valid), .out_ready(a_ready));

	route_split #(.SEL_BIT(DEST_BIT)) dest_split (.clk, .reset_L,
		.in_data(a_data), .in_valid(a_valid), .in_ready(a_ready),
		.out0_data(s2_0_data), .out0_valid(s2_0_valid), .out0_ready(s2_0_ready),
		.out1_data(s2_1_data), .out1_valid(s2_1_valid), .out1_ready(s2_1_ready));

	trans_fifo #(.DEPTH(DEST_DEPTH)) d0_fifo (.clk, .reset_L, .in_data(s2_0_data),
		.in_push(s2_0_valid && s2_0_ready), .out_data(out0_data),
		.out_valid(out0_valid), .out_ready(out0_ready),
		.afull_thr(thr_dest), .status(d0_st));

	trans_fifo #(.DEPTH(DEST_DEPTH)) d1_fifo (.clk, .reset_L, .in_data(s2_1_data),
		.in_push(s2_1_valid && s2_1_ready), .out_data(out1_data),
		.out_valid(out1_valid), .out_ready(out1_ready),
		.afull_thr(thr_dest), .status(d1_st));

	trans_ctrl ctrl (.clk, .reset_L, .init, .cfg,
		.main_stat(main_st), .vc0_stat(vc0_st), .vc1_stat(vc1_st),
		.d0_stat(d0_st), .d1_stat(d1_st),
		.thr_main, .thr_vc, .thr_dest, .active, .idle, .error);

endmodule

//--- hdl/route_split.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// one word register, output picked by bit SEL_BIT of that word
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module route_split
	import trans_pkg::*;
#(
	parameter int SEL_BIT = WORD_W - 1
) (
	input  logic              clk,
	input  logic              reset_L,
	input  logic [WORD_W-1:0] in_data,
	input  logic              in_valid,
	output logic              in_ready,
	output logic [WORD_W-1:0] out0_data,
	output logic              out0_valid,
	input  logic              out0_ready,
	output logic [WORD_W-1:0] out1_data,
	output logic              out1_valid,
	input  logic              out1_ready
);

	logic [WORD_W-1:0] hold_data;
	logic hold_valid;
	logic drain;

	// both sides see the same word, only one sees valid
	assign out0_data = hold_data;
	assign out1_data = hold_data;
	assign out0_valid = hold_valid && !hold_data[SEL_BIT];
	assign out1_valid = hold_valid && hold_data[SEL_BIT];

	assign drain = (out0_valid && out0_ready) || (out1_valid && out1_ready);
	// take a new word when empty or emptying this cycle
	assign in_ready = !hold_valid || drain;

	always_ff @(posedge clk) begin
		if (!reset_L)
			hold_valid <= 1'b0;
		else if (in_ready)
			hold_valid <= in_valid;
	end

	// payload only
	always_ff @(posedge clk) begin
		if (in_valid && in_ready)
			hold_data <= in_data;
	end

	// upstream keeps an offered word until it is taken
	a_in_hold: assert property (@(posedge clk) disable iff (!reset_L)
		in_valid && !in_ready |=> in_valid && $stable(in_data));

endmodule

//--- hdl/trans_fifo.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// push-only input, no back-pressure; a push while full is dropped
// DEPTH at most 31 so the count fits the threshold width
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module trans_fifo
	import trans_pkg::*;
#(
	parameter int DEPTH = 4
) (
	input  logic              clk,
	input  logic              reset_L,
	input  logic [WORD_W-1:0] in_data,
	input  logic              in_push,
	output logic [WORD_W-1:0] out_data,
	output logic              out_valid,
	input  logic              out_ready,
	input  logic [THR_W-1:0]  afull_thr,
	fifo_status_if.producer   status
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	logic [WORD_W-1:0] mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [CW-1:0] count;
	logic [CW-1:0] count_nxt;
	logic do_push;
	logic do_pop;

	// head word straight from the array, valid one cycle after its write
	assign out_data = mem[rd_ptr];
	assign out_valid = !status.empty;

	assign do_pop = out_valid && out_ready;
	// a pop in the same cycle frees a slot
	assign do_push = in_push && (!status.full || do_pop);

	always_comb begin
		count_nxt = count;
		if (do_push && !do_pop)
			count_nxt = count + 1'b1;
		else if (!do_push && do_pop)
			count_nxt = count - 1'b1;
	end

	// word storage
	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= in_data;
	end

	always_ff @(posedge clk) begin
		if (!reset_L) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			status.empty <= 1'b1;
			status.full <= 1'b0;
			status.almost_full <= 1'b0;
			status.overflow <= 1'b0;
		end else begin
			// wrap by compare, works for any depth
			if (do_push)
				wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			count <= count_nxt;
			// flags follow the new count at the same edge
			status.empty <= (count_nxt == '0);
			status.full <= (count_nxt == CW'(DEPTH));
			status.almost_full <= (THR_W'(count_nxt) >= afull_thr);
			// word lost, nothing popped to make room
			status.overflow <= in_push && status.full && !do_pop;
		end
	end

	// occupancy bound
	a_count_bound: assert property (@(posedge clk) disable iff (!reset_L)
		count <= CW'(DEPTH));

	// stalled head word must not move or change
	a_head_stable: assert property (@(posedge clk) disable iff (!reset_L)
		out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

//--- hdl/vc_arbiter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// strict VC0 priority; VC1 can starve while VC0 keeps data
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module vc_arbiter
	import trans_pkg::*;
(
	input  logic              clk,
	input  logic              reset_L,
	input  logic [WORD_W-1:0] vc0_data,
	input  logic              vc0_valid,
	output logic              vc0_ready,
	input  logic [WORD_W-1:0] vc1_data,
	input  logic              vc1_valid,
	output logic              vc1_ready,
	fifo_status_if.observer   d0_stat,
	fifo_status_if.observer   d1_stat,
	output logic [WORD_W-1:0] out_data,
	output logic              out_valid,
	input  logic              out_ready
);

	logic free;
	logic grant_ok;
	logic take0;
	logic take1;

	// register empty or being drained
	assign free = !out_valid || out_ready;
	// either destination near full stops both VCs
	assign grant_ok = free && !d0_stat.almost_full && !d1_stat.almost_full;

	assign vc0_ready = grant_ok;
	// vc1 only when vc0 has nothing
	assign vc1_ready = grant_ok && !vc0_valid;

	assign take0 = vc0_valid && vc0_ready;
	assign take1 = vc1_valid && vc1_ready;

	always_ff @(posedge clk) begin
		if (!reset_L)
			out_valid <= 1'b0;
		else if (free)
			out_valid <= take0 || take1;
	end

	always_ff @(posedge clk) begin
		if (take0)
			out_data <= vc0_data;
		else if (take1)
			out_data <= vc1_data;
	end

	// destination FIFOs never pushed past full
	a_dest_no_ovf: assert property (@(posedge clk) disable iff (!reset_L)
		!d0_stat.overflow && !d1_stat.overflow);

endmodule

//--- list.f
+incdir+tb
common/trans_pkg.sv
common/fifo_status_if.sv
hdl/trans_fifo.sv
hdl/route_split.sv
hdl/vc_arbiter.sv
control/trans_ctrl.sv
hdl/pcie_trans.sv
tb/pcie_trans_tb.sv

//--- tb/pcie_trans_tasks.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// driver, scoreboard and test tasks; included inside the testbench module
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef PCIE_TRANS_TASKS_SVH
`define PCIE_TRANS_TASKS_SVH

task automatic report_failure(input string msg);
	$display("%s", msg);
	$display("Testbench failed");
	$fatal(1);
endtask

task automatic check_word(input string name, input logic [WORD_W-1:0] exp,
	input logic [WORD_W-1:0] act);
	if (exp !== act)
		report_failure($sformatf("Fail %s expected %h actual %h", name, exp, act));
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
	if (exp !== act)
		report_failure($sformatf("Fail %s expected %b actual %b", name, exp, act));
endtask

task automatic check_state(input string name, input ctrl_state_t exp,
	input ctrl_state_t act);
	if (exp !== act)
		report_failure($sformatf("Fail %s expected %s actual %s", name, exp.name(),
			act.name()));
endtask

// no flag high reads as INIT
function automatic ctrl_state_t observed_state();
	if (error)
		return ERROR;
	if (active)
		return ACTIVE;
	if (idle)
		return IDLE;
	return INIT;
endfunction

function automatic bit queues_empty();
	return exp_q[0].size() == 0 && exp_q[1].size() == 0
		&& exp_q[2].size() == 0 && exp_q[3].size() == 0;
endfunction

task automatic take_output(input logic port, input logic [WORD_W-1:0] w);
	int idx;
	idx = {w[VC_BIT], w[DEST_BIT]};
	check_flag({test_name, " dest port"}, w[DEST_BIT], port);
	if (exp_q[idx].size() == 0)
		report_failure($sformatf("%s word %h came out but none was pending", test_name, w));
	check_word(test_name, exp_q[idx][0], w);
	void'(exp_q[idx].pop_front());
endtask

// one cycle of source and sink, pause seen after the edge
task automatic step_source(input bit want, input bit honor, input logic [WORD_W-1:0] data,
	input logic r0, input logic r1, output bit did);
	@(posedge clk);
	#1;
	out0_ready = r0;
	out1_ready = r1;
	did = want && (!honor || !pause);
	in_push = did;
	in_data = data;
	if (did)
		exp_q[{data[VC_BIT], data[DEST_BIT]}].push_back(data);
endtask

task automatic apply_reset();
	@(posedge clk);
	#1;
	reset_L = 1'b0;
	in_push = 1'b0;
	init = 1'b0;
	out0_ready = 1'b1;
	out1_ready = 1'b1;
	repeat (10) @(posedge clk);
	#1;
	reset_L = 1'b1;
	for (int i = 0; i < 4; i++)
		exp_q[i].delete();
endtask

task automatic wait_drained();
	int n;
	bit did;
	n = 0;
	while (!(idle && queues_empty())) begin
		step_source(1'b0, 1'b1, '0, 1'b1, 1'b1, did);
		n++;
		if (n > 1000)
			report_failure({test_name, ": pipeline did not drain to idle"});
	end
endtask

// outputs stalled, push until pause stays high
task automatic fill_until_pause(input bit fixed_route, output int pushed);
	int calm;
	bit did;
	logic [WORD_W-1:0] w;
	calm = 0;
	pushed = 0;
	while (calm < 30) begin
		// fixed route is vc0 to dest0
		w = fixed_route ? WORD_W'(pushed & 15) : WORD_W'($random(seed));
		step_source(1'b1, 1'b1, w, 1'b0, 1'b0, did);
		if (did) begin
			pushed++;
			calm = 0;
		end else begin
			calm++;
		end
	end
endtask

task automatic run_traffic(input int n, input bit toggle);
	int sent;
	bit did;
	logic r0;
	logic r1;
	sent = 0;
	while (sent < n) begin
		r0 = toggle ? 1'($random(seed)) : 1'b1;
		r1 = toggle ? 1'($random(seed)) : 1'b1;
		step_source(1'b1, 1'b1, WORD_W'($random(seed)), r0, r1, did);
		if (did)
			sent++;
	end
	wait_drained();
endtask

task automatic test_reset_flags();
	test_name = "reset_flags";
	apply_reset();
	check_flag("reset pause", 1'b0, pause);
	check_flag("reset out0_valid", 1'b0, out0_valid);
	check_flag("reset out1_valid", 1'b0, out1_valid);
	check_flag("reset active", 1'b0, active);
	check_flag("reset idle", 1'b0, idle);
	check_flag("reset error", 1'b0, error);
	repeat (3) @(posedge clk);
	#1;
	check_state(test_name, IDLE, observed_state());
	check_flag("reset pause idle", 1'b0, pause);
	check_flag("idle out0_valid", 1'b0, out0_valid);
	check_flag("idle out1_valid", 1'b0, out1_valid);
endtask

task automatic test_init_thresholds();
	int def_cnt;
	int small_cnt;
	test_name = "init_thresholds";
	apply_reset();
	fill_until_pause(1'b1, def_cnt);
	wait_drained();
	apply_reset();
	// main 1, vc 12, dest 1
	init = 1'b1;
	cfg = {5'd1, 5'd12, 5'd1};
	repeat (4) begin
		@(posedge clk);
		#1;
		check_state("init flags", INIT, observed_state());
	end
	init = 1'b0;
	repeat (2) @(posedge clk);
	#1;
	check_state("after init", IDLE, observed_state());
	fill_until_pause(1'b1, small_cnt);
	check_flag("small thresholds pause earlier", 1'b1, small_cnt < def_cnt);
	wait_drained();
endtask

task automatic test_routing();
	test_name = "routing";
	apply_reset();
	repeat (3) @(posedge clk);
	saw_active = 1'b0;
	run_traffic(200, 1'b0);
	check_flag("routing active seen", 1'b1, saw_active);
	check_state("routing end", IDLE, observed_state());
endtask

task automatic test_backpressure();
	test_name = "backpressure";
	run_traffic(200, 1'b1);
	check_flag("backpressure error", 1'b0, error);
endtask

task automatic test_stall_pause();
	int pushed;
	test_name = "stall_pause";
	apply_reset();
	repeat (3) @(posedge clk);
	fill_until_pause(1'b0, pushed);
	check_flag("stall pause bound", 1'b1,
		pushed <= MAIN_D + 2 * VC_D + 2 * DEST_D + STAGE_REGS);
	wait_drained();
	check_flag("stall error", 1'b0, error);
endtask

task automatic test_overflow();
	int n;
	bit did;
	test_name = "overflow";
	apply_reset();
	repeat (3) @(posedge clk);
	n = 0;
	while (!error && n < 100) begin
		step_source(1'b1, 1'b0, WORD_W'($random(seed)), 1'b0, 1'b0, did);
		n++;
	end
	if (!error)
		report_failure("error did not rise while pushing into a full FIFO");
	in_push = 1'b0;
	check_flag("overflow idle", 1'b0, idle);
	check_flag("overflow active", 1'b0, active);
	init = 1'b1;
	repeat (3) begin
		@(posedge clk);
		#1;
		check_state("error holds over init", ERROR, observed_state());
	end
	init = 1'b0;
	apply_reset();
	repeat (3) @(posedge clk);
	#1;
	check_state("idle after new reset", IDLE, observed_state());
endtask

`endif

//--- tb/pcie_trans_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// directed tests on pcie_trans; first error ends the run
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module pcie_trans_tb
	import trans_pkg::*;
();

	localparam int MAIN_D = 4;
	localparam int VC_D = 16;
	localparam int DEST_D = 4;
	// split, arbiter, split
	localparam int STAGE_REGS = 3;
	// two 200 word runs at a few cycles a word, plus fills and drains
	localparam int CYCLE_LIMIT = 20000;

	logic clk;
	logic reset_L;
	logic init;
	logic [CFG_W-1:0] cfg;
	logic [WORD_W-1:0] in_data;
	logic in_push;
	logic pause;
	logic [WORD_W-1:0] out0_data;
	logic out0_valid;
	logic out0_ready;
	logic [WORD_W-1:0] out1_data;
	logic out1_valid;
	logic out1_ready;
	logic active;
	logic idle;
	logic error;

	// expected words, indexed by {vc, dest}
	logic [WORD_W-1:0] exp_q [4][$];
	integer seed;
	int cycles;
	bit saw_active;
	string test_name;

	pcie_trans #(
		.MAIN_DEPTH(MAIN_D),
		.VC_DEPTH(VC_D),
		.DEST_DEPTH(DEST_D)
	) dut0 (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	`include "pcie_trans_tasks.svh"

	// run length guard
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT)
			report_failure("run went past the cycle limit, a test is stuck");
	end

	// output monitor, scoreboard match per queue
	always @(posedge clk) begin
		if (reset_L) begin
			if (out0_valid && out0_ready)
				take_output(1'b0, out0_data);
			if (out1_valid && out1_ready)
				take_output(1'b1, out1_data);
			if (active)
				saw_active = 1'b1;
		end
	end

	initial begin
		reset_L = 1'b0;
		init = 1'b0;
		cfg = '0;
		in_data = '0;
		in_push = 1'b0;
		out0_ready = 1'b1;
		out1_ready = 1'b1;
		cycles = 0;
		saw_active = 1'b0;
		seed = 16816;
		test_name = "none";
		test_reset_flags();
		test_init_thresholds();
		test_routing();
		test_backpressure();
		test_stall_pause();
		test_overflow();
		$display("Testbench passed");
		$finish;
	end

endmodule
